/* files.f */
+incdir+source
source/ea_pkg.sv
source/op_queue.sv
source/full_reg_bank.sv
source/idx_addr.sv
source/operand_reader.sv
source/ea_top.sv
tb/ea_props.sv
tb/ea_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the effective-address testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f files.f --top-module ea_tb -o ea_sim \
    && ./obj_dir/ea_sim | tee /dev/stderr | grep -qx '>>> PASS' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

exit 0

/* tb/ea_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the effective-address stage
// Streams instruction bytes, models a Wishbone memory and
// checks every operand against a shadow register model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ea_defines.svh"

module ea_tb;

    // About 60 instructions at under 30 cycles each with wide margin
    localparam int TIMEOUT_CYCLES = 4000;

    typedef struct packed {
        logic                  pad;             // Result read and thrown away
        logic [`EA_ADDR_W-1:0] addr;
    } exp_t;

    logic               clk;
    logic               rst;
    logic               byte_valid;
    logic [7:0]         byte_data;
    logic               byte_ready;
    ea_pkg::reg_load_t  load;
    ea_pkg::wb_m2s_t    wb_o;
    ea_pkg::wb_s2m_t    wb_i;
    logic               done;
    ea_pkg::ea_result_t result;

    integer      seed = 32'hce0c_5d50;
    logic [7:0]  stream [$];                    // Bytes not yet accepted
    exp_t        exp_q [$];                     // Results still owed, in order
    exp_t        exp_head;
    logic [7:0]  junk;
    logic [31:0] regs_m [8];                    // Shadow of the full registers
    logic        gaps = 1'b0;                   // Random holes and long acks
    int          wait_left = 0;
    int          cycles = 0;
    int          errors = 0;
    int          tests = 0;

    ea_top u_ea_top (
        .clk(clk), .rst(rst),
        .byte_valid(byte_valid), .byte_data(byte_data), .byte_ready(byte_ready),
        .load(load), .wb_o(wb_o), .wb_i(wb_i),
        .done(done), .result(result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d results outstanding",
                     cycles, exp_q.size());
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] mem_word(input logic [23:0] adr);
        mem_word = {8'h00, adr} * 32'h0101_0001 + 32'h0000_005a;
    endfunction

    // Memory slave with a random number of wait states
    always @(posedge clk) begin
        wb_i.ack <= 1'b0;
        if (wb_o.cyc && wb_o.stb && !wb_i.ack) begin
            check("wb_o.we", {31'd0, wb_o.we}, 32'd0);
            check("wb_o.sel", {28'd0, wb_o.sel}, 32'h0000_000f);
            if (wait_left == 0) begin
                wb_i.ack  <= 1'b1;
                wb_i.dat  <= mem_word(wb_o.adr);
                wait_left <= $random(seed) & (gaps ? 7 : 3);
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    // Byte source
    always @(posedge clk) begin
        if (byte_valid && byte_ready)
            junk = stream.pop_front();          // Taken on this edge
        if (stream.size() != 0 && !(gaps && ($random(seed) & 3) == 0)) begin
            byte_valid <= 1'b1;
            byte_data  <= stream[0];
        end else begin
            byte_valid <= 1'b0;
        end
    end

    // In-order result monitor
    always @(posedge clk) begin
        if (done) begin
            if (exp_q.size() == 0) begin
                $display("Operand returned at %0t with no instruction pending", $time);
                errors++;
            end else begin
                exp_head = exp_q.pop_front();
                if (!exp_head.pad) begin
                    check("result.addr", {8'h00, result.addr}, {8'h00, exp_head.addr});
                    check("result.data", result.data, mem_word(exp_head.addr));
                end
            end
        end
    end

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic push_byte(input logic [7:0] b);
        stream.push_back(b);
    endtask

    task automatic expect_addr(input logic [23:0] a);
        exp_q.push_back('{pad: 1'b0, addr: a});
    endtask

    task automatic load_reg(input logic [2:0] r, input logic [31:0] v);
        @(posedge clk);
        load <= '{en: 1'b1, idx: r, data: v};
        @(posedge clk);
        load.en <= 1'b0;
        regs_m[r] = v;
    endtask

    // (r32) or (r32+d8)
    task automatic emit_reg(input logic [2:0] r, input logic use_d8, input logic [7:0] d8);
        push_byte({4'b0000, use_d8, r});
        if (use_d8)
            push_byte(d8);
        expect_addr(regs_m[r][23:0] + (use_d8 ? {{16{d8[7]}}, d8} : 24'd0));
    endtask

    // len 1, 2, 3 for n8, n16, n24
    task automatic emit_abs(input logic [1:0] len, input logic [23:0] a);
        push_byte({6'b010000, len - 2'd1});
        push_byte(a[7:0]);
        if (len > 2'd1)
            push_byte(a[15:8]);
        if (len > 2'd2)
            push_byte(a[23:16]);
        expect_addr(a);
    endtask

    // Mode 0x13 with sub-mode 0 or 1
    task automatic emit_disp16(input logic [2:0] r, input logic use_d16,
                               input logic [15:0] d16);
        push_byte(8'h43);
        push_byte({3'b111, r, 1'b0, use_d16});
        if (use_d16) begin
            push_byte(d16[7:0]);
            push_byte(d16[15:8]);
        end
        expect_addr(regs_m[r][23:0] + (use_d16 ? {{8{d16[15]}}, d16} : 24'd0));
    endtask

    // Mode 0x13 sub-mode 2 where bit 2 of byte 1 picks a 16-bit index
    task automatic emit_index(input logic [2:0] base, input logic [2:0] aux,
                              input logic wide);
        logic [23:0] ofs;
        ofs = wide ? {{8{regs_m[aux][15]}}, regs_m[aux][15:0]}
                   : {{16{regs_m[aux][7]}}, regs_m[aux][7:0]};
        push_byte(8'h43);
        push_byte({5'b11100, wide, 2'b10});
        push_byte({3'b111, base, 2'b00});
        push_byte({3'b111, aux, 2'b00});
        expect_addr(regs_m[base][23:0] + ofs);
    endtask

    // Pre-decrement (post low) or post-increment with step code 0/1/2
    task automatic emit_step(input logic post, input logic [2:0] r, input logic [1:0] code);
        logic [31:0] step;
        step = (code == 2'd0) ? 32'd1 : (code == 2'd1) ? 32'd2 : 32'd4;
        push_byte({7'b0100010, post});
        push_byte({3'b111, r, code});
        if (post) begin
            expect_addr(regs_m[r][23:0]);
            regs_m[r] = regs_m[r] + step;
        end else begin
            regs_m[r] = regs_m[r] - step;
            expect_addr(regs_m[r][23:0]);
        end
    endtask

    // Pads the stream, waits for every result, reports the test
    task automatic finish_test(input string name, input int err_before);
        push_byte(8'h40);
        push_byte(8'h00);
        exp_q.push_back('{pad: 1'b1, addr: '0});
        while (exp_q.size() != 0 || stream.size() != 0)
            @(posedge clk);
        tests++;
        if (errors == err_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - err_before);
    endtask

    task automatic test_reg_disp();
        int e0;
        e0 = errors;
        load_reg(3'd4, 32'h1234_5678);          // XIX
        load_reg(3'd7, 32'h00ff_fff0);          // XSP
        emit_reg(3'd4, 1'b0, 8'h00);
        emit_reg(3'd4, 1'b1, 8'h10);
        emit_reg(3'd4, 1'b1, 8'h80);
        emit_reg(3'd7, 1'b0, 8'h00);
        emit_reg(3'd7, 1'b1, 8'h20);            // Wraps past 24 bits
        emit_reg(3'd7, 1'b1, 8'hf0);
        finish_test("register and d8", e0);
    endtask

    task automatic test_absolute();
        int e0;
        e0 = errors;
        emit_abs(2'd1, 24'h00_007f);
        emit_abs(2'd2, 24'h00_beef);
        emit_abs(2'd3, 24'hab_cdef);
        emit_abs(2'd1, 24'h00_00ff);
        finish_test("absolute", e0);
    endtask

    task automatic test_disp16();
        int e0;
        e0 = errors;
        load_reg(3'd2, 32'h0010_0000);          // XDE
        emit_disp16(3'd2, 1'b0, 16'h0000);
        emit_disp16(3'd2, 1'b1, 16'h1234);
        emit_disp16(3'd2, 1'b1, 16'h8000);
        finish_test("register and d16", e0);
    endtask

    task automatic test_index();
        int e0;
        e0 = errors;
        load_reg(3'd3, 32'h0040_0000);          // XHL base
        load_reg(3'd1, 32'h0000_80f0);          // Negative byte and halfword
        load_reg(3'd0, 32'h0000_0123);
        emit_index(3'd3, 3'd1, 1'b0);
        emit_index(3'd3, 3'd1, 1'b1);
        emit_index(3'd3, 3'd0, 1'b0);
        emit_index(3'd3, 3'd0, 1'b1);
        finish_test("register index", e0);
    endtask

    task automatic test_step();
        int e0;
        e0 = errors;
        load_reg(3'd5, 32'h0000_2000);          // XIY
        emit_step(1'b1, 3'd5, 2'd0);
        emit_reg(3'd5, 1'b0, 8'h00);
        emit_step(1'b0, 3'd5, 2'd2);
        emit_reg(3'd5, 1'b0, 8'h00);
        emit_step(1'b1, 3'd5, 2'd1);
        emit_reg(3'd5, 1'b0, 8'h00);
        emit_step(1'b0, 3'd5, 2'd0);
        emit_step(1'b0, 3'd5, 2'd1);
        emit_step(1'b1, 3'd5, 2'd2);
        emit_reg(3'd5, 1'b0, 8'h00);
        finish_test("pre-decrement and post-increment", e0);
    endtask

    task automatic test_backpressure();
        int          e0;
        logic [31:0] rnd;
        e0 = errors;
        gaps = 1'b1;
        repeat (20) begin
            rnd = $random(seed);
            case (rnd[2:0])
                3'd0: emit_reg(rnd[5:3], 1'b0, 8'h00);
                3'd1: emit_reg(rnd[5:3], 1'b1, rnd[15:8]);
                3'd2: emit_abs(2'd1, {16'h0000, rnd[15:8]});
                3'd3: emit_disp16(rnd[5:3], 1'b1, rnd[31:16]);
                3'd4: emit_index(rnd[5:3], rnd[8:6], rnd[9]);
                3'd5: emit_step(rnd[6], rnd[5:3], (rnd[8:7] == 2'd3) ? 2'd2 : rnd[8:7]);
                3'd6: emit_abs(2'd2, {8'h00, rnd[31:16]});
                default: emit_abs(2'd3, rnd[31:8]);
            endcase
        end
        finish_test("back-pressure mix", e0);
        gaps = 1'b0;
    endtask

    initial begin
        rst        = 1'b1;
        byte_valid = 1'b0;
        byte_data  = 8'h00;
        load       = '0;
        wb_i       = '0;
        for (int i = 0; i < 8; i++)
            regs_m[i] = 32'h0;                  // Bank clears at reset
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_reg_disp();
        test_absolute();
        test_disp16();
        test_index();
        test_step();
        test_backpressure();
        $display("Summary: %0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* tb/ea_props.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone and strobe assertions for the
// effective-address stage, bound into ea_top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ea_props (
    input logic            clk,
    input logic            rst,
    input ea_pkg::wb_m2s_t wb_o,
    input ea_pkg::wb_s2m_t wb_i,
    input logic            addr_ok,
    input logic            done
);

    stb_needs_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_o.stb |-> wb_o.cyc)
        else $error("stb high without cyc");

    // Address held until the slave answers
    adr_stable: assert property (@(posedge clk) disable iff (rst)
        wb_o.stb && !wb_i.ack |=> $stable(wb_o.adr))
        else $error("address changed while waiting for ack");

    no_strobe_in_read: assert property (@(posedge clk) disable iff (rst)
        !(addr_ok && wb_o.cyc))
        else $error("address strobe during an active read");

    done_one_cycle: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else $error("done held longer than one cycle");

endmodule

bind ea_top ea_props u_ea_props (
    .clk(clk), .rst(rst), .wb_o(wb_o), .wb_i(wb_i),
    .addr_ok(addr_ok), .done(done)
);

/* source/ea_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Effective-address stage top level
// Byte stream in, one Wishbone read out, operand on done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ea_defines.svh"

module ea_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      byte_valid,
    input  logic [7:0]                byte_data,
    output logic                      byte_ready,
    input  ea_pkg::reg_load_t         load,
    output ea_pkg::wb_m2s_t           wb_o,
    input  ea_pkg::wb_s2m_t           wb_i,
    output logic                      done,
    output ea_pkg::ea_result_t        result
);

    logic [15:0]           op;
    logic                  op_valid;
    logic [1:0]            fetched;
    logic                  advance;
    ea_pkg::idx_rd_t       rd;
    logic [`EA_DATA_W-1:0] idx_rdreg;
    logic [15:0]           idx_rdaux;
    logic                  addr_ok;
    logic [`EA_ADDR_W-1:0] idx_addr;
    logic                  busy;

    op_queue u_op_queue (
        .clk(clk), .rst(rst),
        .byte_valid(byte_valid), .byte_data(byte_data), .byte_ready(byte_ready),
        .fetched(fetched), .advance(advance),
        .op(op), .op_valid(op_valid)
    );

    full_reg_bank u_full_reg_bank (
        .clk(clk), .rst(rst),
        .load(load), .rd(rd),
        .idx_rdreg(idx_rdreg), .idx_rdaux(idx_rdaux)
    );

    idx_addr u_idx_addr (
        .clk(clk), .rst(rst),
        .op(op), .op_valid(op_valid), .busy(busy),
        .fetched(fetched), .advance(advance),
        .rd(rd), .idx_rdreg(idx_rdreg), .idx_rdaux(idx_rdaux),
        .addr_ok(addr_ok), .idx_addr(idx_addr)
    );

    operand_reader u_operand_reader (
        .clk(clk), .rst(rst),
        .addr_ok(addr_ok), .idx_addr(idx_addr), .busy(busy),
        .wb_o(wb_o), .wb_i(wb_i),
        .done(done), .result(result)
    );

endmodule

/* source/operand_reader.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic read master
// One 32-bit read per address strobe, result on done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ea_defines.svh"

module operand_reader (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  addr_ok,
    input  logic [`EA_ADDR_W-1:0] idx_addr,
    output logic                  busy,
    output ea_pkg::wb_m2s_t       wb_o,
    input  ea_pkg::wb_s2m_t       wb_i,
    output logic                  done,
    output ea_pkg::ea_result_t    result
);

    logic                  cyc;
    logic                  start;
    logic                  finish;
    logic [`EA_ADDR_W-1:0] adr;
    logic [`EA_DATA_W-1:0] dat;

    assign start  = addr_ok && !cyc;
    assign finish = cyc && wb_i.ack;
    assign busy   = addr_ok || cyc;     // Covers the strobe cycle too

    always_comb begin
        wb_o.cyc    = cyc;
        wb_o.stb    = cyc;              // Single beat, so stb follows cyc
        wb_o.we     = 1'b0;
        wb_o.adr    = adr;
        wb_o.sel    = 4'hf;
        result.addr = adr;
        result.data = dat;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc  <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= finish;
            if (start)
                cyc <= 1'b1;
            else if (finish)
                cyc <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            adr <= idx_addr;
        if (finish)
            dat <= wb_i.dat;
    end

endmodule

/* source/idx_addr.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory-addressing prefix decoder
// Phase 0 reads the mode byte, phase 1 gathers upper bytes;
// forms the 24-bit effective address with a strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ea_defines.svh"

module idx_addr (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [15:0]           op,
    input  logic                  op_valid,
    input  logic                  busy,
    output logic [1:0]            fetched,
    output logic                  advance,
    output ea_pkg::idx_rd_t       rd,
    input  logic [`EA_DATA_W-1:0] idx_rdreg,
    input  logic [15:0]           idx_rdaux,
    output logic                  addr_ok,
    output logic [`EA_ADDR_W-1:0] idx_addr
);

    logic                  cen;
    logic                  phase;
    logic                  nx_phase;
    logic [4:0]            mode;            // {byte0[6], byte0[3:0]}
    logic [1:0]            ridx_mode;       // {index used, 16-bit index}
    logic [1:0]            nx_ridx_mode;
    logic [`EA_ADDR_W-1:0] offset;
    logic [`EA_ADDR_W-1:0] nx_offset;
    logic [`EA_ADDR_W-1:0] aux24;
    logic                  nx_addr_ok;
    ea_pkg::idx_rd_t       nx_rd;

    function automatic logic [`EA_ADDR_W-1:0] step_bytes(input logic [1:0] step);
        case (step)
            `EA_STEP_1: step_bytes = 'd1;
            `EA_STEP_2: step_bytes = 'd2;
            default:    step_bytes = 'd4;
        endcase
    endfunction

    assign cen     = op_valid && !busy;
    assign advance = cen;

    always_comb begin
        aux24 = ridx_mode[0] ? {{8{idx_rdaux[15]}}, idx_rdaux}
                             : {{16{idx_rdaux[7]}}, idx_rdaux[7:0]};
        idx_addr = idx_rdreg[`EA_ADDR_W-1:0] + (ridx_mode[1] ? aux24 : offset);
    end

    always_comb begin
        fetched      = 2'd2;
        nx_phase     = 1'b0;
        nx_addr_ok   = 1'b0;
        nx_ridx_mode = 2'd0;
        nx_offset    = offset;
        nx_rd        = rd;
        nx_rd.inc    = 1'b0;
        nx_rd.dec    = 1'b0;
        if (!phase) begin
            nx_rd.aux_sel = `EA_SEL_NULL;
            casez ({op[6], op[3:0]})
                5'b0_????: begin                // (r32) or (r32+d8)
                    nx_rd.rd_sel = `EA_SEL_FULL | {3'b000, op[2:0], 2'b00};
                    nx_offset    = op[3] ? {{16{op[15]}}, op[15:8]} : '0;
                    fetched      = op[3] ? 2'd2 : 2'd1;
                    nx_addr_ok   = 1'b1;
                end
                5'h10: begin                    // (n8)
                    nx_rd.rd_sel = `EA_SEL_NULL;
                    nx_offset    = {16'd0, op[15:8]};
                    nx_addr_ok   = 1'b1;
                end
                5'h11, 5'h12: begin             // (n16), (n24) low byte
                    nx_rd.rd_sel = `EA_SEL_NULL;
                    nx_offset    = {16'd0, op[15:8]};
                    nx_phase     = 1'b1;
                end
                5'h13: begin
                    nx_rd.rd_sel = {op[15:10], 2'b00};
                    nx_offset    = '0;
                    case (op[9:8])
                        2'd1: nx_phase = 1'b1;  // d16 follows
                        2'd2: begin             // Index register follows
                            nx_phase     = 1'b1;
                            nx_ridx_mode = {1'b1, op[10]};
                        end
                        default: nx_addr_ok = 1'b1;
                    endcase
                end
                5'h14, 5'h15: begin             // (-r32) and (r32+)
                    nx_rd.rd_sel = {op[15:10], 2'b00};
                    nx_rd.step   = op[9:8];
                    nx_rd.dec    = !op[0];
                    nx_rd.inc    = op[0];
                    nx_offset    = op[0] ? '0 : '0 - step_bytes(op[9:8]);
                    nx_addr_ok   = 1'b1;
                end
                default: ;                      // Unknown prefix dropped
            endcase
        end else begin
            case (mode)
                5'h11: begin
                    nx_offset[`EA_ADDR_W-1:8] = {8'h00, op[7:0]};
                    fetched = 2'd1;
                end
                5'h12: nx_offset[`EA_ADDR_W-1:8] = op;
                default: begin                  // Mode 0x13 second half
                    nx_ridx_mode = ridx_mode;
                    if (ridx_mode[1]) begin
                        nx_rd.rd_sel  = op[7:0];
                        nx_rd.aux_sel = op[15:8];
                    end else begin
                        nx_offset = {{8{op[15]}}, op};
                    end
                end
            endcase
            nx_addr_ok = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase     <= 1'b0;
            mode      <= 5'd0;
            ridx_mode <= 2'd0;
            addr_ok   <= 1'b0;
            rd        <= '{rd_sel: `EA_SEL_NULL, aux_sel: `EA_SEL_NULL,
                           step: `EA_STEP_1, inc: 1'b0, dec: 1'b0};
        end else if (cen) begin
            phase     <= nx_phase;
            ridx_mode <= nx_ridx_mode;
            addr_ok   <= nx_addr_ok;
            rd        <= nx_rd;
            if (!phase)
                mode <= {op[6], op[3:0]};
        end else begin
            addr_ok <= 1'b0;                    // Strobes last one cycle
            rd.inc  <= 1'b0;
            rd.dec  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cen)
            offset <= nx_offset;
    end

endmodule

/* source/full_reg_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Eight 32-bit full registers, XWA to XSP
// Byte-addressed reads for base and index, external load,
// and the step update for pre-decrement and post-increment
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "ea_defines.svh"

module full_reg_bank (
    input  logic                  clk,
    input  logic                  rst,
    input  ea_pkg::reg_load_t     load,
    input  ea_pkg::idx_rd_t       rd,
    output logic [`EA_DATA_W-1:0] idx_rdreg,
    output logic [15:0]           idx_rdaux
);

    logic [`EA_DATA_W-1:0] regs [8];
    logic [`EA_DATA_W-1:0] aux_word;
    logic [`EA_DATA_W-1:0] step_val;
    logic                  rd_full;

    // Register at a byte select, shifted down by the byte offset
    function automatic logic [`EA_DATA_W-1:0] sel_read(input logic [7:0] sel);
        if ((sel & `EA_SEL_FULL) == `EA_SEL_FULL)
            sel_read = regs[sel[4:2]] >> {sel[1:0], 3'b000};
        else
            sel_read = '0;                      // NULL and unmapped selects
    endfunction

    always_comb begin
        idx_rdreg = sel_read(rd.rd_sel);
        aux_word  = sel_read(rd.aux_sel);
        idx_rdaux = aux_word[15:0];             // Low halfword or byte used
    end

    assign rd_full = ((rd.rd_sel & `EA_SEL_FULL) == `EA_SEL_FULL);

    always_comb begin
        case (rd.step)
            `EA_STEP_1: step_val = 32'd1;
            `EA_STEP_2: step_val = 32'd2;
            default:    step_val = 32'd4;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (load.en) begin
            regs[load.idx] <= load.data;        // Load wins over a step
        end else if (rd_full && rd.inc) begin
            regs[rd.rd_sel[4:2]] <= regs[rd.rd_sel[4:2]] + step_val;
        end else if (rd_full && rd.dec) begin
            regs[rd.rd_sel[4:2]] <= regs[rd.rd_sel[4:2]] - step_val;
        end
    end

endmodule

/* source/op_queue.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four-byte instruction fetch queue
// Bytes enter one per cycle, the decoder retires 0 to 2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module op_queue (
    input  logic        clk,
    input  logic        rst,
    input  logic        byte_valid,
    input  logic [7:0]  byte_data,
    output logic        byte_ready,
    input  logic [1:0]  fetched,
    input  logic        advance,
    output logic [15:0] op,
    output logic        op_valid
);

    logic [3:0][7:0] q;         // Entry 0 is the oldest byte
    logic [3:0][7:0] nx_q;
    logic [2:0]      count;
    logic [2:0]      nx_count;
    logic [2:0]      ret;
    logic [2:0]      kept;
    logic            settled;   // Holds ready low for one cycle after reset
    logic            push;

    assign byte_ready = settled && (count != 3'd4);
    assign push       = byte_valid && byte_ready;
    assign op         = {q[1], q[0]};
    assign op_valid   = (count >= 3'd2);

    always_comb begin
        ret  = advance ? {1'b0, fetched} : 3'd0;
        kept = count - ret;
        nx_q = q >> {ret, 3'b000};              // Retire from the bottom
        nx_count = kept;
        if (push) begin
            nx_q[kept[1:0]] = byte_data;        // Append behind survivors
            nx_count = kept + 3'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count   <= 3'd0;
            settled <= 1'b0;
        end else begin
            count   <= nx_count;
            settled <= 1'b1;
        end
    end

    // Byte storage
    always_ff @(posedge clk) begin
        q <= nx_q;
    end

endmodule

/* source/ea_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packed structs passed between the queue, decoder,
// register bank, operand reader and the outside world
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ea_pkg;

`include "ea_defines.svh"

    // External register load, used by the testbench
    typedef struct packed {
        logic                  en;
        logic [2:0]            idx;     // XWA..XSP
        logic [`EA_DATA_W-1:0] data;
    } reg_load_t;

    // Decoder request to the register bank
    typedef struct packed {
        logic [7:0] rd_sel;             // Base register byte select
        logic [7:0] aux_sel;            // Index register byte select
        logic [1:0] step;
        logic       inc;
        logic       dec;
    } idx_rd_t;

    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`EA_ADDR_W-1:0] adr;
        logic [3:0]            sel;
    } wb_m2s_t;

    typedef struct packed {
        logic [`EA_DATA_W-1:0] dat;
        logic                  ack;
    } wb_s2m_t;

    typedef struct packed {
        logic [`EA_ADDR_W-1:0] addr;
        logic [`EA_DATA_W-1:0] data;
    } ea_result_t;

endpackage

/* source/ea_defines.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and encodings shared by the effective-address stage
// Include wherever a width or register select is needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef EA_DEFINES_SVH
`define EA_DEFINES_SVH

`define EA_ADDR_W   24      // Effective address
`define EA_DATA_W   32      // Full register and operand

// Byte-address register selects
`define EA_SEL_NULL 8'h40   // Reads as zero
`define EA_SEL_FULL 8'he0   // XWA at E0, XSP at FC

// Step codes for pre-decrement and post-increment
`define EA_STEP_1   2'd0
`define EA_STEP_2   2'd1
`define EA_STEP_4   2'd2

`endif
